//--- source/riscboy_pkg.sv
// Bus widths, address map, AHB-Lite and APB structs, transfer types and GPIO offsets
package riscboy_pkg;

	localparam int W_ADDR  = 32;
	localparam int W_DATA  = 32;
	localparam int W_PADDR = 16;

	// ==================================================
	// Address map
	// ==================================================
	// A region matches when the masked address equals its base
	localparam logic [W_ADDR-1:0] SRAM_BASE = 32'h2000_0000;
	localparam logic [W_ADDR-1:0] SRAM_MASK = 32'he000_0000;
	localparam logic [W_ADDR-1:0] APB_BASE  = 32'h4000_0000;
	localparam logic [W_ADDR-1:0] APB_MASK  = 32'he000_0000;

	// GPIO register offsets within the APB space
	localparam logic [W_PADDR-1:0] GPIO_OUT = 16'h0000;
	localparam logic [W_PADDR-1:0] GPIO_OE  = 16'h0004;
	localparam logic [W_PADDR-1:0] GPIO_IN  = 16'h0008;

	// ==================================================
	// Bus types
	// ==================================================
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_BUSY   = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} htrans_t;

	// AHB-Lite address phase
	typedef struct packed {
		logic [W_ADDR-1:0] haddr;
		logic              hwrite;
		htrans_t           htrans;
		logic [2:0]        hsize;
	} ahb_req_t;

	typedef struct packed {
		logic              hready_resp;
		logic              hresp;
		logic [W_DATA-1:0] hrdata;
	} ahb_resp_t;

	typedef struct packed {
		logic [W_PADDR-1:0] paddr;
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [W_DATA-1:0]  pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [W_DATA-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_resp_t;

endpackage

//--- source/ahbl_splitter.sv
// AHB-Lite splitter with address decode, data-phase owner tracking and a default error slave
`timescale 1ns/1ps

module ahbl_splitter (
	input  logic                              clk,
	input  logic                              arst_n,
	input  riscboy_pkg::ahb_req_t             ahb_req,
	output logic                              hready,
	output logic                              hresp,
	output logic [riscboy_pkg::W_DATA-1:0]    hrdata,
	output logic                              sram_sel,
	output logic                              apb_sel,
	input  riscboy_pkg::ahb_resp_t            sram_resp,
	input  riscboy_pkg::ahb_resp_t            apb_resp
);
	import riscboy_pkg::*;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_SRAM,
		OWN_APB,
		OWN_DEF
	} owner_t;

	owner_t    owner;
	logic      active;
	logic      def_second;
	ahb_resp_t resp_mux;

	// Decode is purely on the address, slaves qualify with htrans and hready
	assign sram_sel = (ahb_req.haddr & SRAM_MASK) == SRAM_BASE;
	assign apb_sel  = (ahb_req.haddr & APB_MASK) == APB_BASE;
	assign active   = ahb_req.htrans == HTRANS_NONSEQ || ahb_req.htrans == HTRANS_SEQ;

	// ==================================================
	// Data phase ownership
	// ==================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			owner      <= OWN_NONE;
			def_second <= 1'b0;
		end else begin
			if (hready) begin
				if (!active)
					owner <= OWN_NONE;
				else if (sram_sel)
					owner <= OWN_SRAM;
				else if (apb_sel)
					owner <= OWN_APB;
				else
					owner <= OWN_DEF;
				def_second <= 1'b0;
			end else if (owner == OWN_DEF) begin
				// First error cycle done, second one releases the bus
				def_second <= 1'b1;
			end
		end
	end

	// ==================================================
	// Response multiplexer
	// ==================================================
	always_comb begin
		case (owner)
			OWN_SRAM: resp_mux = sram_resp;
			OWN_APB:  resp_mux = apb_resp;
			OWN_DEF: begin
				resp_mux.hready_resp = def_second;
				resp_mux.hresp       = 1'b1;
				resp_mux.hrdata      = '0;
			end
			default: begin
				resp_mux.hready_resp = 1'b1;
				resp_mux.hresp       = 1'b0;
				resp_mux.hrdata      = '0;
			end
		endcase
	end

	assign hready = resp_mux.hready_resp;
	assign hresp  = resp_mux.hresp;
	assign hrdata = resp_mux.hrdata;

endmodule

//--- source/ahb_sync_sram.sv
// Zero-wait-state synchronous SRAM with an AHB-Lite slave port and byte-lane writes
`timescale 1ns/1ps

module ahb_sync_sram #(
	parameter int SRAM_DEPTH = 1024
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           sel,
	input  logic                           hready,
	input  riscboy_pkg::ahb_req_t          ahb_req,
	input  logic [riscboy_pkg::W_DATA-1:0] hwdata,
	output riscboy_pkg::ahb_resp_t         resp
);
	import riscboy_pkg::*;

	localparam int W_IDX = $clog2(SRAM_DEPTH);

	logic [W_DATA-1:0] mem [SRAM_DEPTH];

	logic             accept;
	logic [3:0]       lanes;
	logic [3:0]       lanes_q;
	logic [W_IDX-1:0] idx_q;
	logic             wr_pending;

	assign accept = sel && hready &&
		(ahb_req.htrans == HTRANS_NONSEQ || ahb_req.htrans == HTRANS_SEQ);

	// Byte enables from transfer size and the low address bits
	always_comb begin
		case (ahb_req.hsize)
			3'b000:  lanes = 4'b0001 << ahb_req.haddr[1:0];
			3'b001:  lanes = ahb_req.haddr[1] ? 4'b1100 : 4'b0011;
			default: lanes = 4'b1111;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wr_pending <= 1'b0;
		else if (hready)
			wr_pending <= accept && ahb_req.hwrite;
	end

	// Address phase capture
	always_ff @(posedge clk) begin
		if (accept) begin
			idx_q   <= ahb_req.haddr[2 +: W_IDX];
			lanes_q <= lanes;
		end
	end

	// Write commits on the edge that ends the data phase
	always_ff @(posedge clk) begin
		if (wr_pending && hready) begin
			for (int b = 0; b < 4; b++) begin
				if (lanes_q[b])
					mem[idx_q][b*8 +: 8] <= hwdata[b*8 +: 8];
			end
		end
	end

	assign resp.hready_resp = 1'b1;
	assign resp.hresp       = 1'b0;
	assign resp.hrdata      = mem[idx_q];

endmodule

//--- source/ahbl_to_apb.sv
// AHB-Lite to APB bridge FSM with one setup and access sequence per transfer
`timescale 1ns/1ps

module ahbl_to_apb (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           sel,
	input  logic                           hready,
	input  riscboy_pkg::ahb_req_t          ahb_req,
	input  logic [riscboy_pkg::W_DATA-1:0] hwdata,
	output riscboy_pkg::ahb_resp_t         resp,
	output riscboy_pkg::apb_req_t          apb_req,
	input  riscboy_pkg::apb_resp_t         apb_resp
);
	import riscboy_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		WR_WAIT,
		SETUP,
		ACCESS,
		ERR1,
		ERR2
	} state_t;

	state_t             state;
	state_t             state_nxt;
	logic               accept;
	logic [W_PADDR-1:0] paddr_q;
	logic               pwrite_q;
	logic [W_DATA-1:0]  pwdata_q;

	assign accept = sel && hready &&
		(ahb_req.htrans == HTRANS_NONSEQ || ahb_req.htrans == HTRANS_SEQ);

	// ==================================================
	// State machine
	// ==================================================
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    if (accept) state_nxt = WR_WAIT;
			WR_WAIT: state_nxt = SETUP;
			SETUP:   state_nxt = ACCESS;
			ACCESS: begin
				if (apb_resp.pready) begin
					if (apb_resp.pslverr)
						state_nxt = ERR1;
					else
						state_nxt = accept ? WR_WAIT : IDLE;
				end
			end
			ERR1:    state_nxt = ERR2;
			ERR2:    state_nxt = accept ? WR_WAIT : IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// Address and control latched at acceptance, write data one cycle later
	always_ff @(posedge clk) begin
		if (accept) begin
			paddr_q  <= ahb_req.haddr[W_PADDR-1:0];
			pwrite_q <= ahb_req.hwrite;
		end
		if (state == WR_WAIT)
			pwdata_q <= hwdata;
	end

	// ==================================================
	// Bus outputs
	// ==================================================
	assign apb_req.paddr   = paddr_q;
	assign apb_req.psel    = state == SETUP || state == ACCESS;
	assign apb_req.penable = state == ACCESS;
	assign apb_req.pwrite  = pwrite_q;
	assign apb_req.pwdata  = pwdata_q;

	always_comb begin
		resp.hrdata = apb_resp.prdata;
		case (state)
			IDLE: begin
				resp.hready_resp = 1'b1;
				resp.hresp       = 1'b0;
			end
			ACCESS: begin
				// Completes together with the APB access unless it errors
				resp.hready_resp = apb_resp.pready && !apb_resp.pslverr;
				resp.hresp       = 1'b0;
			end
			ERR1: begin
				resp.hready_resp = 1'b0;
				resp.hresp       = 1'b1;
			end
			ERR2: begin
				resp.hready_resp = 1'b1;
				resp.hresp       = 1'b1;
			end
			default: begin
				resp.hready_resp = 1'b0;
				resp.hresp       = 1'b0;
			end
		endcase
	end

endmodule

//--- source/apb_gpio.sv
// APB GPIO block with output, output-enable and synchronized input registers
`timescale 1ns/1ps

module apb_gpio #(
	parameter int N_PADS = 16
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  riscboy_pkg::apb_req_t  apb_req,
	output riscboy_pkg::apb_resp_t apb_resp,
	input  logic [N_PADS-1:0]      gpio_in,
	output logic [N_PADS-1:0]      gpio_out,
	output logic [N_PADS-1:0]      gpio_oe
);
	import riscboy_pkg::*;

	logic [N_PADS-1:0] out_q;
	logic [N_PADS-1:0] oe_q;
	logic [N_PADS-1:0] in_meta;
	logic [N_PADS-1:0] in_sync;
	logic              access;
	logic              bad_access;

	assign access = apb_req.psel && apb_req.penable;

	// Unknown offsets and writes to the input register are rejected
	always_comb begin
		case (apb_req.paddr)
			GPIO_OUT, GPIO_OE: bad_access = 1'b0;
			GPIO_IN:           bad_access = apb_req.pwrite;
			default:           bad_access = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_q   <= '0;
			oe_q    <= '0;
			in_meta <= '0;
			in_sync <= '0;
		end else begin
			in_meta <= gpio_in;
			in_sync <= in_meta;
			if (access && apb_req.pwrite && !bad_access) begin
				if (apb_req.paddr == GPIO_OUT)
					out_q <= apb_req.pwdata[N_PADS-1:0];
				else
					oe_q <= apb_req.pwdata[N_PADS-1:0];
			end
		end
	end

	always_comb begin
		case (apb_req.paddr)
			GPIO_OUT: apb_resp.prdata = W_DATA'(out_q);
			GPIO_OE:  apb_resp.prdata = W_DATA'(oe_q);
			GPIO_IN:  apb_resp.prdata = W_DATA'(in_sync);
			default:  apb_resp.prdata = '0;
		endcase
	end

	assign apb_resp.pready  = 1'b1;
	assign apb_resp.pslverr = access && bad_access;

	assign gpio_out = out_q;
	assign gpio_oe  = oe_q;

endmodule

//--- source/riscboy_fabric.sv
// Bus fabric top level with splitter, SRAM, AHB-Lite to APB bridge and GPIO
`timescale 1ns/1ps

module riscboy_fabric #(
	parameter int SRAM_DEPTH = 1024,
	parameter int N_PADS     = 16
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  riscboy_pkg::ahb_req_t          ahb_req,
	input  logic [riscboy_pkg::W_DATA-1:0] hwdata,
	output logic                           hready,
	output logic                           hresp,
	output logic [riscboy_pkg::W_DATA-1:0] hrdata,
	input  logic [N_PADS-1:0]              gpio_in,
	output logic [N_PADS-1:0]              gpio_out,
	output logic [N_PADS-1:0]              gpio_oe
);
	import riscboy_pkg::*;

	logic      sram_sel;
	logic      apb_sel;
	ahb_resp_t sram_resp;
	ahb_resp_t apb_resp;
	apb_req_t  bridge_apb_req;
	apb_resp_t gpio_apb_resp;

	// ==================================================
	// Bus fabric
	// ==================================================
	ahbl_splitter splitter_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.ahb_req   (ahb_req),
		.hready    (hready),
		.hresp     (hresp),
		.hrdata    (hrdata),
		.sram_sel  (sram_sel),
		.apb_sel   (apb_sel),
		.sram_resp (sram_resp),
		.apb_resp  (apb_resp)
	);

	// ==================================================
	// Slaves
	// ==================================================
	ahb_sync_sram #(
		.SRAM_DEPTH (SRAM_DEPTH)
	) sram_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.sel     (sram_sel),
		.hready  (hready),
		.ahb_req (ahb_req),
		.hwdata  (hwdata),
		.resp    (sram_resp)
	);

	ahbl_to_apb bridge_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.sel      (apb_sel),
		.hready   (hready),
		.ahb_req  (ahb_req),
		.hwdata   (hwdata),
		.resp     (apb_resp),
		.apb_req  (bridge_apb_req),
		.apb_resp (gpio_apb_resp)
	);

	apb_gpio #(
		.N_PADS (N_PADS)
	) gpio_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.apb_req  (bridge_apb_req),
		.apb_resp (gpio_apb_resp),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.gpio_oe  (gpio_oe)
	);

endmodule

//--- dv/riscboy_fabric_assertions.sv
// Concurrent assertions on APB phase order, the AHB-Lite error response and address hold
`timescale 1ns/1ps

module riscboy_fabric_assertions (
	input logic                  clk,
	input logic                  arst_n,
	input riscboy_pkg::ahb_req_t ahb_req,
	input logic                  hready,
	input logic                  hresp,
	input riscboy_pkg::apb_req_t apb_req
);
	import riscboy_pkg::*;

	logic pending;

	assign pending = ahb_req.htrans == HTRANS_NONSEQ || ahb_req.htrans == HTRANS_SEQ;

	// Access phase only after one setup cycle
	apb_setup_first: assert property (@(posedge clk) disable iff (!arst_n)
		apb_req.penable |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable))
		else $error("penable high without an APB setup cycle before it");

	// Two-cycle error response
	ahb_error_two_cycles: assert property (@(posedge clk) disable iff (!arst_n)
		hresp && !hready |=> hresp && hready)
		else $error("first error cycle not followed by the second error cycle");

	// Master holds the address phase while stalled
	ahb_addr_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!hready && pending |=> $stable(ahb_req))
		else $error("address phase changed while hready was low");

endmodule

//--- dv/riscboy_fabric_tb.sv
// Testbench with a pipelined random AHB-Lite master, reference model and checks
`timescale 1ns/1ps

module riscboy_fabric_tb;
	import riscboy_pkg::*;

	localparam int SRAM_DEPTH     = 1024;
	localparam int N_PADS         = 16;
	localparam int TIMEOUT_CYCLES = 20;

	typedef struct packed {
		logic        valid;
		logic        write;
		logic [31:0] addr;
		logic [2:0]  size;
		logic [31:0] wdata;
		logic [31:0] exp_rdata;
		logic        exp_err;
	} xfer_t;

	logic              clk = 1'b0;
	logic              arst_n;
	ahb_req_t          ahb_req;
	logic [W_DATA-1:0] hwdata;
	logic              hready;
	logic              hresp;
	logic [W_DATA-1:0] hrdata;
	logic [N_PADS-1:0] gpio_in;
	logic [N_PADS-1:0] gpio_out;
	logic [N_PADS-1:0] gpio_oe;

	// Model state in issue order, pad copies in completion order
	logic [31:0]       sram_model [SRAM_DEPTH];
	logic [N_PADS-1:0] out_m;
	logic [N_PADS-1:0] oe_m;
	logic [N_PADS-1:0] in_m;
	logic [N_PADS-1:0] pin_out;
	logic [N_PADS-1:0] pin_oe;
	xfer_t             cur;
	xfer_t             dph;
	integer            seed = 32'h3c9c;
	int                errors = 0;
	int                checked = 0;

	riscboy_fabric #(
		.SRAM_DEPTH (SRAM_DEPTH),
		.N_PADS     (N_PADS)
	) riscboy_fabric_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.ahb_req  (ahb_req),
		.hwdata   (hwdata),
		.hready   (hready),
		.hresp    (hresp),
		.hrdata   (hrdata),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.gpio_oe  (gpio_oe)
	);

	bind riscboy_fabric riscboy_fabric_assertions assertions_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ahb_req (ahb_req),
		.hready  (hready),
		.hresp   (hresp),
		.apb_req (bridge_apb_req)
	);

	always #50 clk = ~clk;

	// ==================================================
	// Master and checks
	// ==================================================
	task automatic end_run();
		$display("Transfers checked %0d, errors %0d", checked, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic check_data_phase(input logic err_first);
		if (dph.valid) begin
			checked++;
			if (hresp !== dph.exp_err) begin
				$display("Error: hresp for %h is %h, expected %h", dph.addr, hresp, dph.exp_err);
				errors++;
			end else if (dph.exp_err && err_first !== 1'b1) begin
				$display("Error: first-cycle hresp for %h is %h, expected %h", dph.addr,
					err_first, 1'b1);
				errors++;
			end else if (!dph.write && !dph.exp_err && hrdata !== dph.exp_rdata) begin
				$display("Error: hrdata for %h is %h, expected %h", dph.addr, hrdata,
					dph.exp_rdata);
				errors++;
			end
		end
		if (gpio_out !== pin_out || gpio_oe !== pin_oe) begin
			$display("Error: gpio_out %h gpio_oe %h, expected %h %h", gpio_out, gpio_oe,
				pin_out, pin_oe);
			errors++;
		end
		// Pads follow a GPIO write once its data phase has ended
		if (dph.valid && dph.write && !dph.exp_err) begin
			if (dph.addr == APB_BASE + 32'(GPIO_OUT))
				pin_out = dph.wdata[N_PADS-1:0];
			if (dph.addr == APB_BASE + 32'(GPIO_OE))
				pin_oe = dph.wdata[N_PADS-1:0];
		end
	endtask

	// Waits for the edge that ends the data phase and accepts the address phase
	task automatic advance_pipeline(input xfer_t nxt);
		int       cycles;
		logic     err_first;
		ahb_req_t req;
		cycles = 0;
		err_first = 1'b0;
		@(posedge clk);
		while (!hready && cycles < TIMEOUT_CYCLES) begin
			// hresp of the last stalled cycle
			err_first = hresp;
			@(posedge clk);
			cycles++;
		end
		if (!hready) begin
			$display("Timeout: hready stayed low for %0d cycles at %h", cycles, dph.addr);
			errors++;
			end_run();
		end else begin
			check_data_phase(err_first);
			dph = cur;
			hwdata <= cur.wdata;
			cur = nxt;
			req.haddr  = nxt.addr;
			req.hwrite = nxt.write;
			req.htrans = nxt.valid ? HTRANS_NONSEQ : HTRANS_IDLE;
			req.hsize  = nxt.size;
			ahb_req <= req;
		end
	endtask

	task automatic idle_cycle();
		xfer_t x;
		x = '0;
		advance_pipeline(x);
	endtask

	task automatic issue_transfer(input logic [31:0] addr, input logic write,
		input logic [2:0] size, input logic [31:0] wdata);
		xfer_t x;
		int    idx;
		int    nbytes;
		int    first;
		x = '0;
		x.valid = 1'b1;
		x.write = write;
		x.addr  = addr;
		x.size  = size;
		x.wdata = wdata;
		if ((addr & SRAM_MASK) == SRAM_BASE) begin
			idx    = int'((addr >> 2) % SRAM_DEPTH);
			// A transfer covers its naturally aligned group of bytes in the word
			nbytes = (size > 3'd2) ? 4 : (1 << size);
			first  = int'(addr[1:0]) & ~(nbytes - 1);
			for (int b = first; b < first + nbytes; b++) begin
				if (write)
					sram_model[idx][b*8 +: 8] = wdata[b*8 +: 8];
			end
			x.exp_rdata = sram_model[idx];
		end else if ((addr & APB_MASK) == APB_BASE && addr[15:0] == GPIO_OUT) begin
			if (write)
				out_m = wdata[N_PADS-1:0];
			x.exp_rdata = 32'(out_m);
		end else if ((addr & APB_MASK) == APB_BASE && addr[15:0] == GPIO_OE) begin
			if (write)
				oe_m = wdata[N_PADS-1:0];
			x.exp_rdata = 32'(oe_m);
		end else if ((addr & APB_MASK) == APB_BASE && addr[15:0] == GPIO_IN && !write) begin
			x.exp_rdata = 32'(in_m);
		end else begin
			x.exp_err = 1'b1;
		end
		advance_pipeline(x);
	endtask

	function automatic logic [31:0] sram_word_addr(input logic [31:0] r);
		return SRAM_BASE + ((r % SRAM_DEPTH) << 2);
	endfunction

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		logic [31:0] r;
		logic [31:0] a;
		arst_n  = 1'b0;
		ahb_req = '0;
		hwdata  = '0;
		gpio_in = '0;
		cur     = '0;
		dph     = '0;
		out_m   = '0;
		oe_m    = '0;
		in_m    = '0;
		pin_out = '0;
		pin_oe  = '0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		// Fill every word, then random word traffic back to back
		for (int i = 0; i < SRAM_DEPTH; i++)
			issue_transfer(SRAM_BASE + 32'(i) * 4, 1'b1, 3'd2, $random(seed));
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			issue_transfer(sram_word_addr($random(seed)), r[0], 3'd2, $random(seed));
		end

		// Byte and halfword writes each read back as a word
		for (int i = 0; i < 100; i++) begin
			r = $random(seed);
			a = sram_word_addr($random(seed));
			if (r[0])
				issue_transfer(a + 32'(r[2:1]), 1'b1, 3'd0, $random(seed));
			else
				issue_transfer(a + 32'({r[2], 1'b0}), 1'b1, 3'd1, $random(seed));
			issue_transfer(a, 1'b0, 3'd2, '0);
		end

		// GPIO output registers
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			a = APB_BASE + (r[0] ? 32'(GPIO_OE) : 32'(GPIO_OUT));
			issue_transfer(a, 1'b1, 3'd2, $random(seed));
			issue_transfer(a, 1'b0, 3'd2, '0);
		end

		// GPIO input through the synchronizer, bus idle while the pads settle
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			idle_cycle();
			idle_cycle();
			@(posedge clk);
			gpio_in <= r[N_PADS-1:0];
			in_m = r[N_PADS-1:0];
			repeat (10) @(posedge clk);
			issue_transfer(APB_BASE + 32'(GPIO_IN), 1'b0, 3'd2, '0);
		end

		// Error responses, then read back the state they must not touch
		r = $random(seed);
		issue_transfer(32'h6000_0000 + (r & 32'h0000_0ffc), 1'b1, 3'd2, $random(seed));
		issue_transfer(32'h0000_0100, 1'b0, 3'd2, '0);
		issue_transfer(APB_BASE + 32'h0000_000c, 1'b1, 3'd2, $random(seed));
		issue_transfer(APB_BASE + 32'h0000_0010, 1'b0, 3'd2, '0);
		issue_transfer(APB_BASE + 32'(GPIO_IN), 1'b1, 3'd2, $random(seed));
		issue_transfer(SRAM_BASE + (r & 32'h0000_0ffc), 1'b0, 3'd2, '0);
		issue_transfer(APB_BASE + 32'(GPIO_OUT), 1'b0, 3'd2, '0);
		issue_transfer(APB_BASE + 32'(GPIO_OE), 1'b0, 3'd2, '0);

		// Mixed SRAM and GPIO traffic
		for (int i = 0; i < 300; i++) begin
			r = $random(seed);
			case (r[2:0])
				3'd0, 3'd1: issue_transfer(sram_word_addr($random(seed)), r[3], 3'd2,
					$random(seed));
				3'd2: issue_transfer(sram_word_addr($random(seed)) + 32'(r[4:3]), 1'b1, 3'd0,
					$random(seed));
				3'd3: idle_cycle();
				3'd4: issue_transfer(APB_BASE + 32'(GPIO_IN), 1'b0, 3'd2, '0);
				default: issue_transfer(APB_BASE + (r[4] ? 32'(GPIO_OE) : 32'(GPIO_OUT)), r[3],
					3'd2, $random(seed));
			endcase
		end
		idle_cycle();
		idle_cycle();
		end_run();
	end

endmodule

//--- riscboy_fabric.f
source/riscboy_pkg.sv
source/ahbl_splitter.sv
source/ahb_sync_sram.sv
source/ahbl_to_apb.sv
source/apb_gpio.sv
source/riscboy_fabric.sv
dv/riscboy_fabric_assertions.sv
dv/riscboy_fabric_tb.sv

//--- Bender.yml
package:
  name: riscboy_fabric

sources:
  # Package first, then the slaves and the top level
  - source/riscboy_pkg.sv
  - source/ahbl_splitter.sv
  - source/ahb_sync_sram.sv
  - source/ahbl_to_apb.sv
  - source/apb_gpio.sv
  - source/riscboy_fabric.sv

  - target: simulation
    files:
      - dv/riscboy_fabric_assertions.sv
      - dv/riscboy_fabric_tb.sv
